//--- hw/modulation_pkg.sv
package modulation_pkg;

  // system clock in Hz
  localparam int CLK_FREQ = 20000000;

  // precharge settle phase, 500us at CLK_FREQ
  localparam logic [23:0] PRECHARGE_CYCLES = 24'(CLK_FREQ / 2000);

  ////////////////////
  // switch levels

  // pc switch passes the signal to the integrator
  localparam logic SW_PC_SIGNAL = 1'b1;
  // pc switch on the bootstrapped precharge buffer
  localparam logic SW_PC_BOOT = 1'b0;

  // s1, the pc output. enable bit 3 plus channel 0
  localparam logic [3:0] AZMUX_HI = 4'b1000;

  // buffering downstream, in hi/lo pairs
  localparam logic [2:0] CREDIT_MAX = 3'd4;

  ////////////////////
  // sequencer states, numbered as on the bench

  typedef enum logic [6:0] {
    ST_START          = 7'd0,
    ST_PROTECT        = 7'd1,
    ST_PROTECT_WAIT   = 7'd15,
    ST_SETTLE         = 7'd2,
    ST_SETTLE_WAIT    = 7'd25,
    ST_HI             = 7'd3,
    ST_HI_WAIT        = 7'd35,
    ST_REPROTECT      = 7'd4,
    ST_REPROTECT_WAIT = 7'd45,
    ST_LO             = 7'd5,
    ST_LO_WAIT        = 7'd55,
    ST_IDLE           = 7'd6
  } mod_state_e;

  // which sequencer drives the switches
  typedef enum logic [0:0] {
    MODE_PC = 1'b0,
    MODE_AZ = 1'b1
  } mod_mode_e;

endpackage

//--- hw/sample_modulation_pc.sv
`timescale 1ns/1ns

// pc switch only, azmux left on the hi input. for charge injection testing
module sample_modulation_pc (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic        have_credit,
  input  logic [31:0] sample_duration,
  output logic        pc_ctl,
  output logic        led,
  output logic        idle,
  output logic        pair_done,
  output logic [7:0]  monitor
);

  modulation_pkg::mod_state_e state;

  // remaining clocks of the current phase
  logic [31:0] count_down;

  // safe points for a mode change
  assign idle = (state == modulation_pkg::ST_IDLE) || (state == modulation_pkg::ST_START);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= modulation_pkg::ST_START;
      count_down <= '0;
      pc_ctl     <= modulation_pkg::SW_PC_BOOT;
      led        <= 1'b0;
      monitor    <= '0;
      pair_done  <= 1'b0;
    end
    else if (!enable)
    begin
      // parked while the other sequencer owns the switches
      state     <= modulation_pkg::ST_START;
      pc_ctl    <= modulation_pkg::SW_PC_BOOT;
      led       <= 1'b0;
      monitor   <= '0;
      pair_done <= 1'b0;
    end
    else
    begin
      // free running, every entry state reloads it
      count_down <= count_down - 32'd1;
      pair_done  <= 1'b0;

      case (state)
        modulation_pkg::ST_START:
          if (have_credit)
            state <= modulation_pkg::ST_PROTECT;

        ////////////////////
        // pc to boot, signal protected
        modulation_pkg::ST_PROTECT:
        begin
          state      <= modulation_pkg::ST_PROTECT_WAIT;
          count_down <= 32'(modulation_pkg::PRECHARGE_CYCLES);
          pc_ctl     <= modulation_pkg::SW_PC_BOOT;
          monitor    <= '0;
        end
        modulation_pkg::ST_PROTECT_WAIT:
          if (count_down == 32'd0)
            state <= modulation_pkg::ST_SETTLE;

        ////////////////////
        // precharge settle, az would move to hi here
        modulation_pkg::ST_SETTLE:
        begin
          state      <= modulation_pkg::ST_SETTLE_WAIT;
          count_down <= 32'(modulation_pkg::PRECHARGE_CYCLES);
          monitor[0] <= 1'b1;
        end
        modulation_pkg::ST_SETTLE_WAIT:
          if (count_down == 32'd0)
            state <= modulation_pkg::ST_HI;

        ////////////////////
        // pc to signal, hi measurement
        modulation_pkg::ST_HI:
        begin
          state      <= modulation_pkg::ST_HI_WAIT;
          count_down <= sample_duration;
          pc_ctl     <= modulation_pkg::SW_PC_SIGNAL;
          led        <= 1'b1;
          monitor[1] <= 1'b1;
        end
        modulation_pkg::ST_HI_WAIT:
          if (count_down == 32'd0)
            state <= modulation_pkg::ST_REPROTECT;

        // back to boot before the lo side
        modulation_pkg::ST_REPROTECT:
        begin
          state      <= modulation_pkg::ST_REPROTECT_WAIT;
          count_down <= 32'(modulation_pkg::PRECHARGE_CYCLES);
          pc_ctl     <= modulation_pkg::SW_PC_BOOT;
          led        <= 1'b0;
          monitor[1] <= 1'b0;
        end
        modulation_pkg::ST_REPROTECT_WAIT:
          if (count_down == 32'd0)
            state <= modulation_pkg::ST_LO;

        ////////////////////
        // lo measurement, same length as hi
        modulation_pkg::ST_LO:
        begin
          state      <= modulation_pkg::ST_LO_WAIT;
          count_down <= sample_duration;
          monitor[0] <= 1'b0;
        end
        modulation_pkg::ST_LO_WAIT:
          if (count_down == 32'd0)
          begin
            state     <= modulation_pkg::ST_IDLE;
            pair_done <= 1'b1;
          end

        // pair_done still high means this pair is not yet charged to the tracker
        modulation_pkg::ST_IDLE:
          if (have_credit && !pair_done)
            state <= modulation_pkg::ST_SETTLE;

        default:
          state <= modulation_pkg::ST_START;
      endcase
    end
  end

endmodule

//--- hw/sample_modulation_az.sv
`timescale 1ns/1ns

// auto-zero sequencer that alternates the azmux between hi and the chosen lo input
module sample_modulation_az (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic        have_credit,
  input  logic [31:0] sample_duration,
  input  logic [3:0]  azmux_lo,
  output logic        pc_ctl,
  output logic        led,
  output logic        idle,
  output logic        pair_done,
  output logic [7:0]  monitor,
  output logic [3:0]  azmux
);

  modulation_pkg::mod_state_e state;

  // remaining clocks of the current phase
  logic [31:0] count_down;

  // azmux on the pc output from settle through re-protect
  logic sel_hi;

  assign idle = (state == modulation_pkg::ST_IDLE) || (state == modulation_pkg::ST_START);

  // lo code is live, so a new lo input shows at the next lo phase or in idle
  assign azmux = sel_hi ? modulation_pkg::AZMUX_HI : azmux_lo;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= modulation_pkg::ST_START;
      count_down <= '0;
      sel_hi     <= 1'b0;
      pc_ctl     <= modulation_pkg::SW_PC_BOOT;
      led        <= 1'b0;
      monitor    <= '0;
      pair_done  <= 1'b0;
    end
    else if (!enable)
    begin
      state     <= modulation_pkg::ST_START;
      sel_hi    <= 1'b0;
      pc_ctl    <= modulation_pkg::SW_PC_BOOT;
      led       <= 1'b0;
      monitor   <= '0;
      pair_done <= 1'b0;
    end
    else
    begin
      count_down <= count_down - 32'd1;
      pair_done  <= 1'b0;

      case (state)
        modulation_pkg::ST_START:
          if (have_credit)
            state <= modulation_pkg::ST_PROTECT;

        ////////////////////
        // pc to boot with the mux parked on lo
        modulation_pkg::ST_PROTECT:
        begin
          state      <= modulation_pkg::ST_PROTECT_WAIT;
          count_down <= 32'(modulation_pkg::PRECHARGE_CYCLES);
          pc_ctl     <= modulation_pkg::SW_PC_BOOT;
          sel_hi     <= 1'b0;
          monitor    <= '0;
        end
        modulation_pkg::ST_PROTECT_WAIT:
          if (count_down == 32'd0)
            state <= modulation_pkg::ST_SETTLE;

        ////////////////////
        // mux lo to hi while pc protects the signal
        // charge injection from the mux is absorbed by the boot buffer
        modulation_pkg::ST_SETTLE:
        begin
          state      <= modulation_pkg::ST_SETTLE_WAIT;
          count_down <= 32'(modulation_pkg::PRECHARGE_CYCLES);
          sel_hi     <= 1'b1;
          monitor[0] <= 1'b1;
        end
        modulation_pkg::ST_SETTLE_WAIT:
          if (count_down == 32'd0)
            state <= modulation_pkg::ST_HI;

        ////////////////////
        // pc to signal for the hi measurement
        modulation_pkg::ST_HI:
        begin
          state      <= modulation_pkg::ST_HI_WAIT;
          count_down <= sample_duration;
          pc_ctl     <= modulation_pkg::SW_PC_SIGNAL;
          led        <= 1'b1;
          monitor[1] <= 1'b1;
        end
        modulation_pkg::ST_HI_WAIT:
          if (count_down == 32'd0)
            state <= modulation_pkg::ST_REPROTECT;

        // pc back to boot while the mux stays on hi
        modulation_pkg::ST_REPROTECT:
        begin
          state      <= modulation_pkg::ST_REPROTECT_WAIT;
          count_down <= 32'(modulation_pkg::PRECHARGE_CYCLES);
          pc_ctl     <= modulation_pkg::SW_PC_BOOT;
          led        <= 1'b0;
          monitor[1] <= 1'b0;
        end
        modulation_pkg::ST_REPROTECT_WAIT:
          if (count_down == 32'd0)
          begin
            // mux moves to lo as the lo measurement starts
            state      <= modulation_pkg::ST_LO;
            sel_hi     <= 1'b0;
            monitor[2] <= 1'b1;
          end

        ////////////////////
        // lo measurement with the mux already on lo
        modulation_pkg::ST_LO:
        begin
          state      <= modulation_pkg::ST_LO_WAIT;
          count_down <= sample_duration;
          monitor[0] <= 1'b0;
        end
        modulation_pkg::ST_LO_WAIT:
          if (count_down == 32'd0)
          begin
            state      <= modulation_pkg::ST_IDLE;
            pair_done  <= 1'b1;
            monitor[2] <= 1'b0;
          end

        // wait one cycle for the tracker to charge this pair
        modulation_pkg::ST_IDLE:
          if (have_credit && !pair_done)
            state <= modulation_pkg::ST_SETTLE;

        default:
          state <= modulation_pkg::ST_START;
      endcase
    end
  end

endmodule

//--- hw/sample_credit_tracker.sv
`timescale 1ns/1ns

module sample_credit_tracker (
  input  logic        clk,
  input  logic        reset,
  input  logic        sample_done,
  input  logic        credit_return,
  output logic        have_credit,
  output logic        sample_valid,
  output logic [15:0] sample_count
);

  // pairs the downstream side can still buffer
  logic [2:0] credits;

  // at least one free slot downstream
  assign have_credit = (credits != 3'd0);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      credits      <= modulation_pkg::CREDIT_MAX;
      sample_valid <= 1'b0;
      sample_count <= '0;
    end
    else
    begin
      // spend and return in one cycle cancel out
      // a spend at zero is dropped, as is a return when already full
      if (sample_done && !credit_return && (credits != 3'd0))
        credits <= credits - 3'd1;
      else if (credit_return && !sample_done && (credits != modulation_pkg::CREDIT_MAX))
        credits <= credits + 3'd1;

      // one pulse per finished hi/lo pair
      sample_valid <= sample_done;

      // sequence number, wraps at 16 bits
      if (sample_done)
        sample_count <= sample_count + 16'd1;
    end
  end

endmodule

//--- hw/switch_drive.sv
`timescale 1ns/1ns

module switch_drive (
  input  logic                      clk,
  input  logic                      reset,
  input  modulation_pkg::mod_mode_e mode,
  input  logic                      pc_pc_ctl,
  input  logic                      pc_led,
  input  logic [7:0]                pc_monitor,
  input  logic                      pc_idle,
  input  logic                      pc_pair_done,
  input  logic                      az_pc_ctl,
  input  logic                      az_led,
  input  logic [7:0]                az_monitor,
  input  logic                      az_idle,
  input  logic                      az_pair_done,
  input  logic [3:0]                az_azmux,
  output logic                      enable_pc,
  output logic                      enable_az,
  output logic                      sample_done,
  output logic                      sw_pc_ctl,
  output logic [3:0]                azmux,
  output logic                      led0,
  output logic [7:0]                monitor
);

  modulation_pkg::mod_mode_e active_mode;
  logic                      az_active;
  logic                      active_idle;

  assign az_active   = (active_mode == modulation_pkg::MODE_AZ);
  assign active_idle = az_active ? az_idle : pc_idle;

  // exactly one sequencer runs
  assign enable_az = az_active;
  assign enable_pc = !az_active;

  // completions only count from the sequencer in charge
  assign sample_done = az_active ? az_pair_done : pc_pair_done;

  ////////////////////
  // mode latch

  // takes the request only at a cycle boundary or during reset
  always_ff @(posedge clk)
  begin
    if (active_idle)
      active_mode <= mode;
  end

  ////////////////////
  // registered switch outputs

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sw_pc_ctl <= modulation_pkg::SW_PC_BOOT;
      led0      <= 1'b0;
      monitor   <= '0;
    end
    else
    begin
      sw_pc_ctl <= az_active ? az_pc_ctl : pc_pc_ctl;
      led0      <= az_active ? az_led : pc_led;
      monitor   <= az_active ? az_monitor : pc_monitor;
    end
  end

  // pc mode keeps the mux on the hi input at all times
  always_ff @(posedge clk)
  begin
    azmux <= az_active ? az_azmux : modulation_pkg::AZMUX_HI;
  end

endmodule

//--- hw/modulation_top.sv
`timescale 1ns/1ns

module modulation_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [31:0]               sample_duration,
  input  logic [3:0]                azmux_lo,
  input  modulation_pkg::mod_mode_e mode,
  input  logic                      credit_return,
  output logic                      sw_pc_ctl,
  output logic [3:0]                azmux,
  output logic                      led0,
  output logic [7:0]                monitor,
  output logic                      sample_valid,
  output logic [15:0]               sample_count
);

  // sequencer to driver
  logic       pc_pc_ctl;
  logic       pc_led;
  logic [7:0] pc_monitor;
  logic       pc_idle;
  logic       pc_pair_done;
  logic       az_pc_ctl;
  logic       az_led;
  logic [7:0] az_monitor;
  logic       az_idle;
  logic       az_pair_done;
  logic [3:0] az_azmux;

  // control back to the sequencers and tracker
  logic       enable_pc;
  logic       enable_az;
  logic       have_credit;
  logic       sample_done;

  sample_modulation_pc u_mod_pc (
    .clk             (clk),
    .reset           (reset),
    .enable          (enable_pc),
    .have_credit     (have_credit),
    .sample_duration (sample_duration),
    .pc_ctl          (pc_pc_ctl),
    .led             (pc_led),
    .idle            (pc_idle),
    .pair_done       (pc_pair_done),
    .monitor         (pc_monitor)
  );

  sample_modulation_az u_mod_az (
    .clk             (clk),
    .reset           (reset),
    .enable          (enable_az),
    .have_credit     (have_credit),
    .sample_duration (sample_duration),
    .azmux_lo        (azmux_lo),
    .pc_ctl          (az_pc_ctl),
    .led             (az_led),
    .idle            (az_idle),
    .pair_done       (az_pair_done),
    .monitor         (az_monitor),
    .azmux           (az_azmux)
  );

  sample_credit_tracker u_credit (
    .clk           (clk),
    .reset         (reset),
    .sample_done   (sample_done),
    .credit_return (credit_return),
    .have_credit   (have_credit),
    .sample_valid  (sample_valid),
    .sample_count  (sample_count)
  );

  switch_drive u_drive (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .pc_pc_ctl    (pc_pc_ctl),
    .pc_led       (pc_led),
    .pc_monitor   (pc_monitor),
    .pc_idle      (pc_idle),
    .pc_pair_done (pc_pair_done),
    .az_pc_ctl    (az_pc_ctl),
    .az_led       (az_led),
    .az_monitor   (az_monitor),
    .az_idle      (az_idle),
    .az_pair_done (az_pair_done),
    .az_azmux     (az_azmux),
    .enable_pc    (enable_pc),
    .enable_az    (enable_az),
    .sample_done  (sample_done),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .led0         (led0),
    .monitor      (monitor)
  );

endmodule

//--- testbench/modulation_asserts.sv
`timescale 1ns/1ns

// protocol checks on the top level, bound into modulation_top
module modulation_asserts (
  input logic       clk,
  input logic       reset,
  input logic       sw_pc_ctl,
  input logic       sample_valid,
  input logic       credit_return,
  input logic [2:0] credits
);

  // failed assertions so far, read back by the testbench
  int failures = 0;

  // switches parked and no sample reported while in reset
  reset_quiet: assert property (@(posedge clk)
    reset |-> (sw_pc_ctl == modulation_pkg::SW_PC_BOOT) && !sample_valid)
  else
  begin
    $error("sw_pc_ctl or sample_valid active during reset");
    failures++;
  end

  // one pulse per finished pair, never two in a row
  valid_pulse: assert property (@(posedge clk) disable iff (reset)
    sample_valid |=> !sample_valid)
  else
  begin
    $error("sample_valid held for more than one cycle");
    failures++;
  end

  // downstream may only return what it was given
  return_room: assert property (@(posedge clk) disable iff (reset)
    credit_return |-> (credits != modulation_pkg::CREDIT_MAX))
  else
  begin
    $error("credit_return while the tracker is full");
    failures++;
  end

endmodule

//--- testbench/modulation_tb.sv
`timescale 1ns/1ns

module modulation_tb;

  // longest pair from ST_START with protect, settle and reprotect plus two measurements
  localparam int PAIR_LEN = 3 * (int'(modulation_pkg::PRECHARGE_CYCLES) + 2) + 2 * 202 + 8;
  localparam int WAIT_LIMIT = 2 * PAIR_LEN;

  logic                      clk;
  logic                      reset;
  logic [31:0]               sample_duration;
  logic [3:0]                azmux_lo;
  modulation_pkg::mod_mode_e mode;
  logic                      credit_return;
  logic                      sw_pc_ctl;
  logic [3:0]                azmux;
  logic                      led0;
  logic [7:0]                monitor;
  logic                      sample_valid;
  logic [15:0]               sample_count;

  ////////////////////
  // reference model state
  logic [31:0]               rng;
  logic [15:0]               exp_count;
  int                        credits;
  // mode the registered outputs follow, updated at each sample_valid
  modulation_pkg::mod_mode_e act_mode;
  int                        hi_run;
  int                        lo_run;
  logic [31:0]               hi_expect;
  bit                        lo_seen;
  int                        pulses;
  bit                        auto_return;
  int                        ret_pending;
  int                        ret_wait;

  modulation_top DUT (
    .clk             (clk),
    .reset           (reset),
    .sample_duration (sample_duration),
    .azmux_lo        (azmux_lo),
    .mode            (mode),
    .credit_return   (credit_return),
    .sw_pc_ctl       (sw_pc_ctl),
    .azmux           (azmux),
    .led0            (led0),
    .monitor         (monitor),
    .sample_valid    (sample_valid),
    .sample_count    (sample_count)
  );

  bind modulation_top modulation_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .sw_pc_ctl     (sw_pc_ctl),
    .sample_valid  (sample_valid),
    .credit_return (credit_return),
    .credits       (u_credit.credits)
  );

  // 10 ns period
  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////
  // helpers

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // uniform pick in lo..hi
  task automatic draw(input int lo, input int hi, output int value);
    rng = next_random(rng);
    value = lo + int'(rng % 32'(hi - lo + 1));
  endtask

  task automatic fail_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
      fail_run();
    end
  endtask

  // compares the outputs with the model once per cycle at the falling edge
  task automatic observe();
    if (DUT.u_asserts.failures != 0)
    begin
      $display("a protocol assertion in the bound checker failed");
      fail_run();
    end
    check("led0 span", sw_pc_ctl == modulation_pkg::SW_PC_SIGNAL, led0);
    check("hi monitor", sw_pc_ctl == modulation_pkg::SW_PC_SIGNAL, monitor[1]);
    if (act_mode == modulation_pkg::MODE_PC)
    begin
      check("pc mode azmux", modulation_pkg::AZMUX_HI, azmux);
      check("pc mode lo monitor", 0, monitor[2]);
    end
    else
    begin
      if (sw_pc_ctl == modulation_pkg::SW_PC_SIGNAL)
        check("az mode hi azmux", modulation_pkg::AZMUX_HI, azmux);
      if (monitor[2])
        check("az mode lo azmux", azmux_lo, azmux);
    end
    // signal phase is duration+2 wide
    if (sw_pc_ctl == modulation_pkg::SW_PC_SIGNAL)
    begin
      if (hi_run == 0)
        hi_expect = sample_duration + 32'd2;
      hi_run++;
    end
    else if (hi_run != 0)
    begin
      check("hi phase width", hi_expect, hi_run);
      hi_run = 0;
    end
    // lo measurement follows the same rule
    if (monitor[2])
      lo_run++;
    else if (lo_run != 0)
    begin
      check("lo phase width", sample_duration + 32'd2, lo_run);
      lo_run = 0;
      lo_seen = 1'b1;
    end
    // a finished pair spends a credit and the mode request is latched here
    if (sample_valid)
    begin
      exp_count++;
      pulses++;
      check("credit available", 1, credits > 0);
      credits--;
      if (act_mode == modulation_pkg::MODE_AZ)
        check("az lo phase seen", 1, lo_seen);
      lo_seen = 1'b0;
      act_mode = mode;
      if (auto_return)
        ret_pending++;
    end
    check("sample count", exp_count, sample_count);
  endtask

  // advance one clock and drive any delayed credit return
  task automatic cycle();
    @(negedge clk);
    observe();
    credit_return = 1'b0;
    if (ret_pending > 0)
    begin
      if (ret_wait > 1)
        ret_wait--;
      else if (ret_wait == 1)
      begin
        credit_return = 1'b1;
        credits++;
        ret_pending--;
        ret_wait = 0;
      end
      else
        draw(2, 64, ret_wait);
    end
  endtask

  task automatic give_credit();
    credit_return = 1'b1;
    credits++;
    cycle();
  endtask

  task automatic wait_pulses(input int n, input string what);
    int target;
    int waited;
    target = pulses + n;
    waited = 0;
    while (pulses < target)
    begin
      cycle();
      waited++;
      if (waited > n * WAIT_LIMIT)
      begin
        $display("timeout: no sample_valid while waiting for %s", what);
        fail_run();
      end
    end
  endtask

  task automatic wait_signal_phase();
    int waited;
    waited = 0;
    while (sw_pc_ctl != modulation_pkg::SW_PC_SIGNAL)
    begin
      cycle();
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        $display("timeout: sw_pc_ctl never went to signal");
        fail_run();
      end
    end
  endtask

  // no pulse may show up in a back-pressure window
  task automatic expect_quiet(input int cycles);
    int start;
    start = pulses;
    for (int k = 0; k < cycles; k++)
      cycle();
    check("no sample without credit", start, pulses);
  endtask

  ////////////////////
  // stimulus

  initial
  begin
    int v;
    rng = 74594;
    hi_run = 0;
    lo_run = 0;
    hi_expect = '0;
    lo_seen = 1'b0;
    pulses = 0;
    auto_return = 1'b0;
    ret_pending = 0;
    ret_wait = 0;
    reset = 1'b1;
    credit_return = 1'b0;
    draw(20, 200, v);
    sample_duration = 32'(v);
    draw(0, 15, v);
    azmux_lo = (4'(v) == modulation_pkg::AZMUX_HI) ? 4'(v ^ 1) : 4'(v);
    draw(0, 1, v);
    mode = v ? modulation_pkg::MODE_AZ : modulation_pkg::MODE_PC;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    act_mode = mode;
    exp_count = '0;
    credits = modulation_pkg::CREDIT_MAX;

    // reset values
    check("reset sw_pc_ctl", modulation_pkg::SW_PC_BOOT, sw_pc_ctl);
    check("reset led0", 0, led0);
    check("reset monitor", 0, monitor);
    check("reset sample_valid", 0, sample_valid);
    check("reset sample_count", 0, sample_count);
    check("reset azmux",
      (mode == modulation_pkg::MODE_PC) ? modulation_pkg::AZMUX_HI : azmux_lo, azmux);

    // the initial credits run out and nothing follows until one comes back
    wait_pulses(modulation_pkg::CREDIT_MAX, "the initial credits");
    expect_quiet(3 * PAIR_LEN);
    give_credit();
    wait_pulses(1, "the returned credit");
    expect_quiet(3 * PAIR_LEN);

    // random pairs with delayed returns and mid-pair mode requests
    auto_return = 1'b1;
    give_credit();
    for (int i = 0; i < 10; i++)
    begin
      draw(20, 200, v);
      sample_duration = 32'(v);
      draw(0, 15, v);
      azmux_lo = (4'(v) == modulation_pkg::AZMUX_HI) ? 4'(v ^ 1) : 4'(v);
      wait_signal_phase();
      draw(0, 1, v);
      if (v == 1 || i == 1)
        mode = (mode == modulation_pkg::MODE_PC) ?
          modulation_pkg::MODE_AZ : modulation_pkg::MODE_PC;
      wait_pulses(1, "a random pair");
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- filelist.f
hw/modulation_pkg.sv
hw/sample_modulation_pc.sv
hw/sample_modulation_az.sv
hw/sample_credit_tracker.sv
hw/switch_drive.sv
hw/modulation_top.sv
testbench/modulation_asserts.sv
testbench/modulation_tb.sv
